/* common/ctrlPkg.sv */
package ctrlPkg;

	////////////////////////////////////////////////////////////
	// Instruction fields and codes
	////////////////////////////////////////////////////////////

	typedef enum logic [5:0] {
		opSpecial = 6'd0,
		opRegimm  = 6'd1,
		opJ       = 6'd2,
		opJal     = 6'd3,
		opBeq     = 6'd4,
		opBne     = 6'd5,
		opBlez    = 6'd6,
		opBgtz    = 6'd7,
		opAddi    = 6'd8,
		opAddiu   = 6'd9,
		opSlti    = 6'd10,
		opSltiu   = 6'd11,
		opAndi    = 6'd12,
		opOri     = 6'd13,
		opXori    = 6'd14,
		opLui     = 6'd15,
		opLb      = 6'd32,
		opLh      = 6'd33,
		opLw      = 6'd35,
		opLbu     = 6'd36,
		opLhu     = 6'd37,
		opSb      = 6'd40,
		opSh      = 6'd41,
		opSw      = 6'd43
	} opcodeE;

	typedef enum logic [5:0] {
		fnSll   = 6'd0,
		fnSrl   = 6'd2,
		fnSra   = 6'd3,
		fnSllv  = 6'd4,
		fnSrlv  = 6'd6,
		fnSrav  = 6'd7,
		fnJr    = 6'd8,
		fnJalr  = 6'd9,
		fnMfhi  = 6'd16,
		fnMthi  = 6'd17,
		fnMflo  = 6'd18,
		fnMtlo  = 6'd19,
		fnMult  = 6'd24,
		fnMultu = 6'd25,
		fnDiv   = 6'd26,
		fnDivu  = 6'd27,
		fnAdd   = 6'd32,
		fnAddu  = 6'd33,
		fnSub   = 6'd34,
		fnSubu  = 6'd35,
		fnAnd   = 6'd36,
		fnOr    = 6'd37,
		fnXor   = 6'd38,
		fnNor   = 6'd39,
		fnSlt   = 6'd42,
		fnSltu  = 6'd43
	} functE;

	// Branch kind lives in rt for the regimm group
	typedef enum logic [4:0] {
		rgBltz = 5'd0,
		rgBgez = 5'd1
	} regimmE;

	typedef struct packed {
		opcodeE     op;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] shamt;
		functE      funct;
	} rTypeT;

	typedef struct packed {
		opcodeE      op;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [15:0] imm;
	} iTypeT;

	typedef struct packed {
		opcodeE      op;
		logic [25:0] target;
	} jTypeT;

	typedef union packed {
		rTypeT rType;
		iTypeT iType;
		jTypeT jType;
	} instrWordT;

	////////////////////////////////////////////////////////////
	// Selects and operations
	////////////////////////////////////////////////////////////

	typedef enum logic [1:0] {npcSeq, npcBranchOrJump, npcRegister} npcSelE;
	typedef enum logic {npcOpBranch, npcOpJump} npcOpE;
	typedef enum logic [2:0] {cmpEq, cmpGez, cmpGtz, cmpLez, cmpLtz, cmpNe} cmpOpE;
	typedef enum logic [1:0] {extSign, extZero, extUpper} extOpE;
	typedef enum logic [1:0] {aSelRs, aSelShamt, aSelHiLo} aluASelE;
	typedef enum logic [1:0] {bSelRt, bSelImm, bSelPc8} aluBSelE;

	typedef enum logic [3:0] {
		aluAdd, aluSub, aluAnd, aluOr, aluSrl, aluSra, aluSll,
		aluSlt, aluSltu, aluNor, aluXor, aluPassA, aluPassB
	} aluOpE;

	typedef enum logic [3:0] {
		mdNone, mdMult, mdMultu, mdMthi, mdMtlo, mdMfhi, mdMflo, mdDiv, mdDivu
	} mdOpE;

	typedef enum logic [2:0] {ldWord, ldByteU, ldByteS, ldHalfU, ldHalfS} loadFmtE;
	typedef enum logic [1:0] {stWord, stByte, stHalf} storeFmtE;
	typedef enum logic [1:0] {dstRd, dstRt, dstRa} dstSelE;
	typedef enum logic {wdAlu, wdMem} wdSelE;

	// Tnew and Tuse share one encoding
	typedef logic [1:0] stageT;
	localparam stageT stageNever = 2'd3;

	////////////////////////////////////////////////////////////
	// Control bundles
	////////////////////////////////////////////////////////////

	typedef struct packed {
		npcSelE npcSel;
		npcOpE  npcOp;
		cmpOpE  cmpOp;
		extOpE  extOp;
	} branchCtrlT;

	typedef struct packed {
		aluASelE aluASel;
		aluBSelE aluBSel;
		aluOpE   aluOp;
		mdOpE    mdOp;
		dstSelE  dstSel;
		wdSelE   wdSel;
		logic    grfWe;
	} exCtrlT;

	typedef struct packed {
		logic      memRe;
		logic      memWe;
		loadFmtE   loadFmt;
		storeFmtE  storeFmt;
	} memCtrlT;

	typedef struct packed {
		stageT tuseRs;
		stageT tuseRt;
		stageT tnew;
	} hazardT;

	typedef struct packed {
		exCtrlT  exCtrl;
		memCtrlT memCtrl;
		stageT   tnew;
	} idExCtrlT;

	localparam idExCtrlT idExBubble = '0;

endpackage

/* decode/branchDecode.sv */
module branchDecode (
	input  ctrlPkg::instrWordT  instr,
	output ctrlPkg::branchCtrlT branchCtrl
);

	always_comb begin
		branchCtrl = '0;
		case (instr.jType.op)
			ctrlPkg::opBeq,
			ctrlPkg::opBne,
			ctrlPkg::opBgtz,
			ctrlPkg::opBlez: begin
				branchCtrl.npcSel = ctrlPkg::npcBranchOrJump;
				branchCtrl.npcOp  = ctrlPkg::npcOpBranch;
				branchCtrl.extOp  = ctrlPkg::extSign;
				case (instr.jType.op)
					ctrlPkg::opBeq:  branchCtrl.cmpOp = ctrlPkg::cmpEq;
					ctrlPkg::opBne:  branchCtrl.cmpOp = ctrlPkg::cmpNe;
					ctrlPkg::opBgtz: branchCtrl.cmpOp = ctrlPkg::cmpGtz;
					default:         branchCtrl.cmpOp = ctrlPkg::cmpLez;
				endcase
			end
			ctrlPkg::opRegimm: begin
				if (instr.iType.rt == ctrlPkg::rgBgez) begin
					branchCtrl.npcSel = ctrlPkg::npcBranchOrJump;
					branchCtrl.cmpOp  = ctrlPkg::cmpGez;
				end else if (instr.iType.rt == ctrlPkg::rgBltz) begin
					branchCtrl.npcSel = ctrlPkg::npcBranchOrJump;
					branchCtrl.cmpOp  = ctrlPkg::cmpLtz;
				end
			end
			ctrlPkg::opJ,
			ctrlPkg::opJal: begin
				branchCtrl.npcSel = ctrlPkg::npcBranchOrJump;
				branchCtrl.npcOp  = ctrlPkg::npcOpJump;
			end
			ctrlPkg::opSpecial: begin
				if (instr.rType.funct == ctrlPkg::fnJr || instr.rType.funct == ctrlPkg::fnJalr)
					branchCtrl.npcSel = ctrlPkg::npcRegister;
			end
			// Immediate extension for the decode-stage extender
			ctrlPkg::opAndi,
			ctrlPkg::opOri,
			ctrlPkg::opXori: branchCtrl.extOp = ctrlPkg::extZero;
			ctrlPkg::opLui:  branchCtrl.extOp = ctrlPkg::extUpper;
			default: ;
		endcase
	end

endmodule

/* decode/aluDecode.sv */
module aluDecode (
	input  ctrlPkg::instrWordT instr,
	output ctrlPkg::exCtrlT    exCtrl
);

	always_comb begin
		// Zero is rs/rt operands, add, no md op, rd, alu data, no write
		exCtrl = '0;
		case (instr.rType.op)
			ctrlPkg::opSpecial: begin
				case (instr.rType.funct)
					ctrlPkg::fnAdd,
					ctrlPkg::fnAddu: begin
						exCtrl.aluOp = ctrlPkg::aluAdd;
						exCtrl.grfWe = 1'b1;
					end
					ctrlPkg::fnSub,
					ctrlPkg::fnSubu: begin
						exCtrl.aluOp = ctrlPkg::aluSub;
						exCtrl.grfWe = 1'b1;
					end
					ctrlPkg::fnSlt: begin
						exCtrl.aluOp = ctrlPkg::aluSlt;
						exCtrl.grfWe = 1'b1;
					end
					ctrlPkg::fnSltu: begin
						exCtrl.aluOp = ctrlPkg::aluSltu;
						exCtrl.grfWe = 1'b1;
					end
					ctrlPkg::fnAnd: begin
						exCtrl.aluOp = ctrlPkg::aluAnd;
						exCtrl.grfWe = 1'b1;
					end
					ctrlPkg::fnOr: begin
						exCtrl.aluOp = ctrlPkg::aluOr;
						exCtrl.grfWe = 1'b1;
					end
					ctrlPkg::fnXor: begin
						exCtrl.aluOp = ctrlPkg::aluXor;
						exCtrl.grfWe = 1'b1;
					end
					ctrlPkg::fnNor: begin
						exCtrl.aluOp = ctrlPkg::aluNor;
						exCtrl.grfWe = 1'b1;
					end
					ctrlPkg::fnSll, ctrlPkg::fnSllv: begin
						exCtrl.aluOp = ctrlPkg::aluSll;
						exCtrl.grfWe = 1'b1;
					end
					ctrlPkg::fnSrl, ctrlPkg::fnSrlv: begin
						exCtrl.aluOp = ctrlPkg::aluSrl;
						exCtrl.grfWe = 1'b1;
					end
					ctrlPkg::fnSra, ctrlPkg::fnSrav: begin
						exCtrl.aluOp = ctrlPkg::aluSra;
						exCtrl.grfWe = 1'b1;
					end
					ctrlPkg::fnJalr: begin
						exCtrl.aluBSel = ctrlPkg::bSelPc8;
						exCtrl.aluOp   = ctrlPkg::aluPassB;
						exCtrl.grfWe   = 1'b1;
					end
					ctrlPkg::fnMult:  exCtrl.mdOp = ctrlPkg::mdMult;
					ctrlPkg::fnMultu: exCtrl.mdOp = ctrlPkg::mdMultu;
					ctrlPkg::fnDiv:   exCtrl.mdOp = ctrlPkg::mdDiv;
					ctrlPkg::fnDivu:  exCtrl.mdOp = ctrlPkg::mdDivu;
					ctrlPkg::fnMthi:  exCtrl.mdOp = ctrlPkg::mdMthi;
					ctrlPkg::fnMtlo:  exCtrl.mdOp = ctrlPkg::mdMtlo;
					ctrlPkg::fnMfhi, ctrlPkg::fnMflo: begin
						exCtrl.aluASel = ctrlPkg::aSelHiLo;
						exCtrl.aluOp   = ctrlPkg::aluPassA;
						exCtrl.grfWe   = 1'b1;
						exCtrl.mdOp    = (instr.rType.funct == ctrlPkg::fnMfhi) ?
							ctrlPkg::mdMfhi : ctrlPkg::mdMflo;
					end
					default: ;
				endcase
				// Fixed shifts take the amount from shamt
				if (instr.rType.funct inside {ctrlPkg::fnSll, ctrlPkg::fnSrl, ctrlPkg::fnSra})
					exCtrl.aluASel = ctrlPkg::aSelShamt;
			end
			ctrlPkg::opJal: begin
				exCtrl.aluBSel = ctrlPkg::bSelPc8;
				exCtrl.aluOp   = ctrlPkg::aluPassB;
				exCtrl.dstSel  = ctrlPkg::dstRa;
				exCtrl.grfWe   = 1'b1;
			end
			ctrlPkg::opAddi, ctrlPkg::opAddiu, ctrlPkg::opSlti, ctrlPkg::opSltiu,
			ctrlPkg::opAndi, ctrlPkg::opOri, ctrlPkg::opXori, ctrlPkg::opLui,
			ctrlPkg::opLw, ctrlPkg::opLb, ctrlPkg::opLbu, ctrlPkg::opLh, ctrlPkg::opLhu: begin
				exCtrl.aluBSel = ctrlPkg::bSelImm;
				exCtrl.dstSel  = ctrlPkg::dstRt;
				exCtrl.grfWe   = 1'b1;
				case (instr.rType.op)
					ctrlPkg::opSlti:  exCtrl.aluOp = ctrlPkg::aluSlt;
					ctrlPkg::opSltiu: exCtrl.aluOp = ctrlPkg::aluSltu;
					ctrlPkg::opAndi:  exCtrl.aluOp = ctrlPkg::aluAnd;
					ctrlPkg::opOri:   exCtrl.aluOp = ctrlPkg::aluOr;
					ctrlPkg::opXori:  exCtrl.aluOp = ctrlPkg::aluXor;
					ctrlPkg::opLui:   exCtrl.aluOp = ctrlPkg::aluPassB;
					default:          exCtrl.aluOp = ctrlPkg::aluAdd;
				endcase
				if (instr.rType.op inside {ctrlPkg::opLw, ctrlPkg::opLb, ctrlPkg::opLbu,
						ctrlPkg::opLh, ctrlPkg::opLhu})
					exCtrl.wdSel = ctrlPkg::wdMem;
			end
			// Stores only need the address sum
			ctrlPkg::opSw, ctrlPkg::opSh, ctrlPkg::opSb: exCtrl.aluBSel = ctrlPkg::bSelImm;
			default: ;
		endcase
	end

endmodule

/* decode/memDecode.sv */
module memDecode (
	input  ctrlPkg::instrWordT instr,
	output ctrlPkg::memCtrlT   memCtrl
);

	always_comb begin
		memCtrl = '0;
		case (instr.iType.op)
			ctrlPkg::opLw: begin
				memCtrl.memRe   = 1'b1;
				memCtrl.loadFmt = ctrlPkg::ldWord;
			end
			ctrlPkg::opLb: begin
				memCtrl.memRe   = 1'b1;
				memCtrl.loadFmt = ctrlPkg::ldByteS;
			end
			ctrlPkg::opLbu: begin
				memCtrl.memRe   = 1'b1;
				memCtrl.loadFmt = ctrlPkg::ldByteU;
			end
			ctrlPkg::opLh: begin
				memCtrl.memRe   = 1'b1;
				memCtrl.loadFmt = ctrlPkg::ldHalfS;
			end
			ctrlPkg::opLhu: begin
				memCtrl.memRe   = 1'b1;
				memCtrl.loadFmt = ctrlPkg::ldHalfU;
			end
			ctrlPkg::opSw: begin
				memCtrl.memWe    = 1'b1;
				memCtrl.storeFmt = ctrlPkg::stWord;
			end
			// Partial stores read the word first and merge
			ctrlPkg::opSb: begin
				memCtrl.memRe    = 1'b1;
				memCtrl.memWe    = 1'b1;
				memCtrl.storeFmt = ctrlPkg::stByte;
			end
			ctrlPkg::opSh: begin
				memCtrl.memRe    = 1'b1;
				memCtrl.memWe    = 1'b1;
				memCtrl.storeFmt = ctrlPkg::stHalf;
			end
			default: ;
		endcase
	end

endmodule

/* decode/hazardTiming.sv */
module hazardTiming (
	input  ctrlPkg::instrWordT instr,
	output ctrlPkg::hazardT    hazard
);

	always_comb begin
		hazard.tuseRs = ctrlPkg::stageNever;
		hazard.tuseRt = ctrlPkg::stageNever;
		hazard.tnew   = 2'd0;
		case (instr.rType.op)
			ctrlPkg::opSpecial: begin
				case (instr.rType.funct)
					ctrlPkg::fnAdd, ctrlPkg::fnAddu, ctrlPkg::fnSub, ctrlPkg::fnSubu,
					ctrlPkg::fnSlt, ctrlPkg::fnSltu, ctrlPkg::fnAnd, ctrlPkg::fnOr,
					ctrlPkg::fnXor, ctrlPkg::fnNor, ctrlPkg::fnSllv, ctrlPkg::fnSrlv,
					ctrlPkg::fnSrav: begin
						hazard.tuseRs = 2'd1;
						hazard.tuseRt = 2'd1;
						hazard.tnew   = 2'd1;
					end
					ctrlPkg::fnSll, ctrlPkg::fnSrl, ctrlPkg::fnSra: begin
						hazard.tuseRt = 2'd1;
						hazard.tnew   = 2'd1;
					end
					// Register target is compared in decode
					ctrlPkg::fnJr, ctrlPkg::fnJalr: hazard.tuseRs = 2'd0;
					ctrlPkg::fnMult, ctrlPkg::fnMultu, ctrlPkg::fnDiv, ctrlPkg::fnDivu: begin
						hazard.tuseRs = 2'd1;
						hazard.tuseRt = 2'd1;
					end
					ctrlPkg::fnMthi, ctrlPkg::fnMtlo: hazard.tuseRs = 2'd1;
					ctrlPkg::fnMfhi, ctrlPkg::fnMflo: hazard.tnew = 2'd1;
					default: ;
				endcase
			end
			ctrlPkg::opRegimm: begin
				if (instr.iType.rt == ctrlPkg::rgBgez || instr.iType.rt == ctrlPkg::rgBltz)
					hazard.tuseRs = 2'd0;
			end
			ctrlPkg::opBeq, ctrlPkg::opBne: begin
				hazard.tuseRs = 2'd0;
				hazard.tuseRt = 2'd0;
			end
			ctrlPkg::opBgtz, ctrlPkg::opBlez: hazard.tuseRs = 2'd0;
			ctrlPkg::opAddi, ctrlPkg::opAddiu, ctrlPkg::opSlti, ctrlPkg::opSltiu,
			ctrlPkg::opAndi, ctrlPkg::opOri, ctrlPkg::opXori: begin
				hazard.tuseRs = 2'd1;
				hazard.tnew   = 2'd1;
			end
			ctrlPkg::opLui: hazard.tnew = 2'd1;
			ctrlPkg::opLw, ctrlPkg::opLb, ctrlPkg::opLbu, ctrlPkg::opLh, ctrlPkg::opLhu: begin
				hazard.tuseRs = 2'd1;
				hazard.tnew   = 2'd2;
			end
			// Store data is needed only at the memory stage
			ctrlPkg::opSw, ctrlPkg::opSh, ctrlPkg::opSb: begin
				hazard.tuseRs = 2'd1;
				hazard.tuseRt = 2'd2;
			end
			default: ;
		endcase
	end

endmodule

/* verilog/idExRegister.sv */
module idExRegister (
	input  logic              clk,
	input  logic              rstN,
	input  logic              stall,
	input  logic              flush,
	input  logic              instrValid,
	input  ctrlPkg::exCtrlT   exCtrl,
	input  ctrlPkg::memCtrlT  memCtrl,
	input  ctrlPkg::stageT    tnew,
	output ctrlPkg::idExCtrlT idExCtrl,
	output logic              exValid
);

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			idExCtrl <= ctrlPkg::idExBubble;
			exValid  <= 1'b0;
		end else if (flush) begin
			idExCtrl <= ctrlPkg::idExBubble;
			exValid  <= 1'b0;
		end else if (!stall) begin
			idExCtrl <= instrValid ? {exCtrl, memCtrl, tnew} : ctrlPkg::idExBubble;
			exValid  <= instrValid;
		end
	end

	////////////////////////////////////////////////////////////
	// Checks
	////////////////////////////////////////////////////////////

	bubbleQuiet: assert property (@(posedge clk) disable iff (!rstN)
		!exValid |-> !idExCtrl.exCtrl.grfWe && !idExCtrl.memCtrl.memRe &&
			!idExCtrl.memCtrl.memWe)
		else $error("bubble in execute carries a side effect");

	partialStoreMerge: assert property (@(posedge clk) disable iff (!rstN)
		idExCtrl.memCtrl.memWe && idExCtrl.memCtrl.storeFmt != ctrlPkg::stWord
			|-> idExCtrl.memCtrl.memRe)
		else $error("partial store without merge read");

	loadWritesMem: assert property (@(posedge clk) disable iff (!rstN)
		idExCtrl.memCtrl.memRe && idExCtrl.exCtrl.grfWe
			|-> idExCtrl.exCtrl.wdSel == ctrlPkg::wdMem)
		else $error("load writes back ALU data");

	// Only a link writes back with no result latency
	zeroTnewIsLink: assert property (@(posedge clk) disable iff (!rstN)
		instrValid && exCtrl.grfWe && tnew == 2'd0 |-> exCtrl.aluBSel == ctrlPkg::bSelPc8)
		else $error("writeback decoded without a ready stage");

endmodule

/* verilog/mipsControl.sv */
module mipsControl (
	input  logic                clk,
	input  logic                rstN,
	input  logic                instrValid,
	input  logic                stall,
	input  logic                flush,
	input  ctrlPkg::instrWordT  instr,
	output ctrlPkg::branchCtrlT branchCtrl,
	output ctrlPkg::hazardT     hazard,
	output ctrlPkg::idExCtrlT   idExCtrl,
	output logic                exValid
);

	ctrlPkg::exCtrlT  exCtrl;
	ctrlPkg::memCtrlT memCtrl;

	// Peer decoders on the same word
	branchDecode u_branchDecode (
		.instr      (instr),
		.branchCtrl (branchCtrl)
	);

	aluDecode u_aluDecode (
		.instr  (instr),
		.exCtrl (exCtrl)
	);

	memDecode u_memDecode (
		.instr   (instr),
		.memCtrl (memCtrl)
	);

	hazardTiming u_hazardTiming (
		.instr  (instr),
		.hazard (hazard)
	);

	idExRegister u_idExRegister (
		.clk        (clk),
		.rstN       (rstN),
		.stall      (stall),
		.flush      (flush),
		.instrValid (instrValid),
		.exCtrl     (exCtrl),
		.memCtrl    (memCtrl),
		.tnew       (hazard.tnew),
		.idExCtrl   (idExCtrl),
		.exValid    (exValid)
	);

endmodule

/* verif/mipsControlTb.sv */
module mipsControlTb;

	typedef struct packed {
		ctrlPkg::branchCtrlT br;
		ctrlPkg::exCtrlT     ex;
		ctrlPkg::memCtrlT    mem;
		ctrlPkg::hazardT     hz;
	} expectT;

	logic                clk;
	logic                rstN;
	logic                instrValid;
	logic                stall;
	logic                flush;
	ctrlPkg::instrWordT  instr;
	ctrlPkg::branchCtrlT branchCtrl;
	ctrlPkg::hazardT     hazard;
	ctrlPkg::idExCtrlT   idExCtrl;
	logic                exValid;
	logic [15:0]         lfsrState;

	mipsControl u_mipsControl (
		.clk        (clk),
		.rstN       (rstN),
		.instrValid (instrValid),
		.stall      (stall),
		.flush      (flush),
		.instr      (instr),
		.branchCtrl (branchCtrl),
		.hazard     (hazard),
		.idExCtrl   (idExCtrl),
		.exValid    (exValid)
	);

	always #4 clk = ~clk;

	////////////////////////////////////////////////////////////
	// Stimulus helpers
	////////////////////////////////////////////////////////////

	function automatic logic [15:0] lfsrNext(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	task automatic takeBits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsrState = lfsrNext(lfsrState);
			v = {v[30:0], lfsrState[0]};
		end
	endtask

	task automatic randomRType(input ctrlPkg::functE fn, output ctrlPkg::instrWordT w);
		logic [31:0] bits;
		takeBits(20, bits);
		w.rType.op    = ctrlPkg::opSpecial;
		w.rType.rs    = bits[19:15];
		w.rType.rt    = bits[14:10];
		w.rType.rd    = bits[9:5];
		w.rType.shamt = bits[4:0];
		w.rType.funct = fn;
	endtask

	// Also fills jump targets through rs, rt and imm
	task automatic randomIType(input ctrlPkg::opcodeE op, output ctrlPkg::instrWordT w);
		logic [31:0] bits;
		takeBits(26, bits);
		w.iType.op  = op;
		w.iType.rs  = bits[25:21];
		w.iType.rt  = bits[20:16];
		w.iType.imm = bits[15:0];
	endtask

	////////////////////////////////////////////////////////////
	// Expected values
	////////////////////////////////////////////////////////////

	function automatic ctrlPkg::aluOpE aluOpFor(input ctrlPkg::instrWordT w);
		if (w.rType.op == ctrlPkg::opSpecial) begin
			case (w.rType.funct)
				ctrlPkg::fnSub, ctrlPkg::fnSubu: return ctrlPkg::aluSub;
				ctrlPkg::fnSlt:                  return ctrlPkg::aluSlt;
				ctrlPkg::fnSltu:                 return ctrlPkg::aluSltu;
				ctrlPkg::fnAnd:                  return ctrlPkg::aluAnd;
				ctrlPkg::fnOr:                   return ctrlPkg::aluOr;
				ctrlPkg::fnXor:                  return ctrlPkg::aluXor;
				ctrlPkg::fnNor:                  return ctrlPkg::aluNor;
				ctrlPkg::fnSll, ctrlPkg::fnSllv: return ctrlPkg::aluSll;
				ctrlPkg::fnSrl, ctrlPkg::fnSrlv: return ctrlPkg::aluSrl;
				ctrlPkg::fnSra, ctrlPkg::fnSrav: return ctrlPkg::aluSra;
				default:                         return ctrlPkg::aluAdd;
			endcase
		end
		case (w.rType.op)
			ctrlPkg::opSlti:  return ctrlPkg::aluSlt;
			ctrlPkg::opSltiu: return ctrlPkg::aluSltu;
			ctrlPkg::opAndi:  return ctrlPkg::aluAnd;
			ctrlPkg::opOri:   return ctrlPkg::aluOr;
			ctrlPkg::opXori:  return ctrlPkg::aluXor;
			ctrlPkg::opLui:   return ctrlPkg::aluPassB;
			default:          return ctrlPkg::aluAdd;
		endcase
	endfunction

	function automatic ctrlPkg::mdOpE mdOpFor(input ctrlPkg::instrWordT w);
		if (w.rType.op != ctrlPkg::opSpecial)
			return ctrlPkg::mdNone;
		case (w.rType.funct)
			ctrlPkg::fnMult:  return ctrlPkg::mdMult;
			ctrlPkg::fnMultu: return ctrlPkg::mdMultu;
			ctrlPkg::fnDiv:   return ctrlPkg::mdDiv;
			ctrlPkg::fnDivu:  return ctrlPkg::mdDivu;
			ctrlPkg::fnMthi:  return ctrlPkg::mdMthi;
			ctrlPkg::fnMtlo:  return ctrlPkg::mdMtlo;
			ctrlPkg::fnMfhi:  return ctrlPkg::mdMfhi;
			ctrlPkg::fnMflo:  return ctrlPkg::mdMflo;
			default:          return ctrlPkg::mdNone;
		endcase
	endfunction

	function automatic expectT modelDecode(input ctrlPkg::instrWordT w);
		expectT          e;
		ctrlPkg::opcodeE op;
		ctrlPkg::functE  fn;
		logic isR, aluR, varSh, fixSh, regJump, mdIn, mtHiLo, mfHiLo;
		logic aluI, lui, load, store, brTwo, brOne, brZero, jump, link;
		op      = w.rType.op;
		fn      = w.rType.funct;
		isR     = (op == ctrlPkg::opSpecial);
		aluR    = isR && (fn inside {ctrlPkg::fnAdd, ctrlPkg::fnAddu, ctrlPkg::fnSub,
			ctrlPkg::fnSubu, ctrlPkg::fnSlt, ctrlPkg::fnSltu, ctrlPkg::fnAnd, ctrlPkg::fnOr,
			ctrlPkg::fnXor, ctrlPkg::fnNor});
		varSh   = isR && (fn inside {ctrlPkg::fnSllv, ctrlPkg::fnSrlv, ctrlPkg::fnSrav});
		fixSh   = isR && (fn inside {ctrlPkg::fnSll, ctrlPkg::fnSrl, ctrlPkg::fnSra});
		regJump = isR && (fn inside {ctrlPkg::fnJr, ctrlPkg::fnJalr});
		mdIn    = isR && (fn inside {ctrlPkg::fnMult, ctrlPkg::fnMultu, ctrlPkg::fnDiv,
			ctrlPkg::fnDivu});
		mtHiLo  = isR && (fn inside {ctrlPkg::fnMthi, ctrlPkg::fnMtlo});
		mfHiLo  = isR && (fn inside {ctrlPkg::fnMfhi, ctrlPkg::fnMflo});
		aluI    = op inside {ctrlPkg::opAddi, ctrlPkg::opAddiu, ctrlPkg::opSlti,
			ctrlPkg::opSltiu, ctrlPkg::opAndi, ctrlPkg::opOri, ctrlPkg::opXori};
		lui     = (op == ctrlPkg::opLui);
		load    = op inside {ctrlPkg::opLw, ctrlPkg::opLb, ctrlPkg::opLbu, ctrlPkg::opLh,
			ctrlPkg::opLhu};
		store   = op inside {ctrlPkg::opSw, ctrlPkg::opSh, ctrlPkg::opSb};
		brTwo   = op inside {ctrlPkg::opBeq, ctrlPkg::opBne};
		brOne   = op inside {ctrlPkg::opBgtz, ctrlPkg::opBlez};
		brZero  = (op == ctrlPkg::opRegimm) && (w.iType.rt inside {5'd0, 5'd1});
		jump    = op inside {ctrlPkg::opJ, ctrlPkg::opJal};
		link    = (op == ctrlPkg::opJal) || (isR && fn == ctrlPkg::fnJalr);

		e = '0;
		e.hz.tuseRs = 2'd3;
		e.hz.tuseRt = 2'd3;

		// Next PC and immediate extension
		if (brTwo || brOne || brZero) begin
			e.br.npcSel = ctrlPkg::npcBranchOrJump;
			case (op)
				ctrlPkg::opBeq:  e.br.cmpOp = ctrlPkg::cmpEq;
				ctrlPkg::opBne:  e.br.cmpOp = ctrlPkg::cmpNe;
				ctrlPkg::opBgtz: e.br.cmpOp = ctrlPkg::cmpGtz;
				ctrlPkg::opBlez: e.br.cmpOp = ctrlPkg::cmpLez;
				default: e.br.cmpOp = w.iType.rt[0] ? ctrlPkg::cmpGez : ctrlPkg::cmpLtz;
			endcase
		end else if (jump) begin
			e.br.npcSel = ctrlPkg::npcBranchOrJump;
			e.br.npcOp  = ctrlPkg::npcOpJump;
		end else if (regJump) begin
			e.br.npcSel = ctrlPkg::npcRegister;
		end
		if (op inside {ctrlPkg::opAndi, ctrlPkg::opOri, ctrlPkg::opXori})
			e.br.extOp = ctrlPkg::extZero;
		if (lui)
			e.br.extOp = ctrlPkg::extUpper;

		// Execute and writeback
		if (aluR || varSh || fixSh) begin
			e.ex.aluOp = aluOpFor(w);
			e.ex.grfWe = 1'b1;
			if (fixSh)
				e.ex.aluASel = ctrlPkg::aSelShamt;
		end
		if (aluI || lui || load) begin
			e.ex.aluBSel = ctrlPkg::bSelImm;
			e.ex.aluOp   = aluOpFor(w);
			e.ex.dstSel  = ctrlPkg::dstRt;
			e.ex.grfWe   = 1'b1;
			if (load)
				e.ex.wdSel = ctrlPkg::wdMem;
		end
		if (store)
			e.ex.aluBSel = ctrlPkg::bSelImm;
		if (link) begin
			e.ex.aluBSel = ctrlPkg::bSelPc8;
			e.ex.aluOp   = ctrlPkg::aluPassB;
			e.ex.dstSel  = (op == ctrlPkg::opJal) ? ctrlPkg::dstRa : ctrlPkg::dstRd;
			e.ex.grfWe   = 1'b1;
		end
		if (mfHiLo) begin
			e.ex.aluASel = ctrlPkg::aSelHiLo;
			e.ex.aluOp   = ctrlPkg::aluPassA;
			e.ex.grfWe   = 1'b1;
		end
		e.ex.mdOp = mdOpFor(w);

		// Data memory
		if (load) begin
			e.mem.memRe = 1'b1;
			case (op)
				ctrlPkg::opLbu: e.mem.loadFmt = ctrlPkg::ldByteU;
				ctrlPkg::opLb:  e.mem.loadFmt = ctrlPkg::ldByteS;
				ctrlPkg::opLhu: e.mem.loadFmt = ctrlPkg::ldHalfU;
				ctrlPkg::opLh:  e.mem.loadFmt = ctrlPkg::ldHalfS;
				default:        e.mem.loadFmt = ctrlPkg::ldWord;
			endcase
		end
		if (store) begin
			e.mem.memWe = 1'b1;
			e.mem.memRe = (op != ctrlPkg::opSw);
			if (op == ctrlPkg::opSb)
				e.mem.storeFmt = ctrlPkg::stByte;
			else if (op == ctrlPkg::opSh)
				e.mem.storeFmt = ctrlPkg::stHalf;
		end

		// Hazard timing
		if (aluR || varSh || mdIn) begin
			e.hz.tuseRs = 2'd1;
			e.hz.tuseRt = 2'd1;
		end
		if (fixSh)
			e.hz.tuseRt = 2'd1;
		if (mtHiLo || aluI || load || store)
			e.hz.tuseRs = 2'd1;
		if (regJump || brTwo || brOne || brZero)
			e.hz.tuseRs = 2'd0;
		if (brTwo)
			e.hz.tuseRt = 2'd0;
		if (store)
			e.hz.tuseRt = 2'd2;
		if (aluR || varSh || fixSh || aluI || lui || mfHiLo)
			e.hz.tnew = 2'd1;
		if (load)
			e.hz.tnew = 2'd2;
		return e;
	endfunction

	////////////////////////////////////////////////////////////
	// Checking and timing
	////////////////////////////////////////////////////////////

	task automatic stopOnFailure(input string why);
		$display("%s", why);
		$display("TEST RESULT: FAIL");
		$fatal(1, "simulation stopped");
	endtask

	task automatic compareValue(input string name, input logic [31:0] got,
			input logic [31:0] want);
		if (got !== want)
			stopOnFailure($sformatf("error at %0t: %s is %0h, expected %0h",
				$time, name, got, want));
	endtask

	task automatic nextCycle();
		@(posedge clk);
		#1;
	endtask

	task automatic stepUntilValid(input int limit);
		int n;
		n = 0;
		do begin
			nextCycle();
			n++;
		end while (!exValid && n < limit);
		if (!exValid)
			stopOnFailure($sformatf("exValid did not rise within %0d cycles", limit));
	endtask

	// Called one time unit after a rising edge
	task automatic presentAndCheck(input ctrlPkg::instrWordT w, input logic valid);
		expectT            e;
		ctrlPkg::idExCtrlT want;
		e = modelDecode(w);
		if (valid)
			want = {e.ex, e.mem, e.hz.tnew};
		else
			want = '0;
		instr      = w;
		instrValid = valid;
		#3;
		compareValue("branchCtrl", 32'(branchCtrl), 32'(e.br));
		compareValue("hazard", 32'(hazard), 32'(e.hz));
		if (valid)
			stepUntilValid(1);
		else
			nextCycle();
		compareValue("exValid", 32'(exValid), 32'(valid));
		compareValue("idExCtrl.exCtrl", 32'(idExCtrl.exCtrl), 32'(want.exCtrl));
		compareValue("idExCtrl.memCtrl", 32'(idExCtrl.memCtrl), 32'(want.memCtrl));
		compareValue("idExCtrl.tnew", 32'(idExCtrl.tnew), 32'(want.tnew));
	endtask

	////////////////////////////////////////////////////////////
	// Directed tests
	////////////////////////////////////////////////////////////

	task automatic afterResetIdle();
		compareValue("exValid", 32'(exValid), 32'd0);
		compareValue("grfWe", 32'(idExCtrl.exCtrl.grfWe), 32'd0);
		compareValue("memRe", 32'(idExCtrl.memCtrl.memRe), 32'd0);
		compareValue("memWe", 32'(idExCtrl.memCtrl.memWe), 32'd0);
	endtask

	task automatic aluAndHiLoOps();
		ctrlPkg::functE     fns[$];
		ctrlPkg::opcodeE    ops[$];
		ctrlPkg::instrWordT w;
		fns = '{ctrlPkg::fnAdd, ctrlPkg::fnAddu, ctrlPkg::fnSub, ctrlPkg::fnSubu,
			ctrlPkg::fnSlt, ctrlPkg::fnSltu, ctrlPkg::fnAnd, ctrlPkg::fnOr, ctrlPkg::fnXor,
			ctrlPkg::fnNor, ctrlPkg::fnSll, ctrlPkg::fnSrl, ctrlPkg::fnSra, ctrlPkg::fnSllv,
			ctrlPkg::fnSrlv, ctrlPkg::fnSrav, ctrlPkg::fnMult, ctrlPkg::fnMultu,
			ctrlPkg::fnDiv, ctrlPkg::fnDivu, ctrlPkg::fnMthi, ctrlPkg::fnMtlo,
			ctrlPkg::fnMfhi, ctrlPkg::fnMflo};
		ops = '{ctrlPkg::opAddi, ctrlPkg::opAddiu, ctrlPkg::opSlti, ctrlPkg::opSltiu,
			ctrlPkg::opAndi, ctrlPkg::opOri, ctrlPkg::opXori, ctrlPkg::opLui};
		foreach (fns[i]) begin
			randomRType(fns[i], w);
			presentAndCheck(w, 1'b1);
		end
		foreach (ops[i]) begin
			randomIType(ops[i], w);
			presentAndCheck(w, 1'b1);
		end
	endtask

	task automatic loadStoreOps();
		ctrlPkg::opcodeE    ops[$];
		ctrlPkg::instrWordT w;
		ops = '{ctrlPkg::opLw, ctrlPkg::opLb, ctrlPkg::opLbu, ctrlPkg::opLh,
			ctrlPkg::opLhu, ctrlPkg::opSw, ctrlPkg::opSh, ctrlPkg::opSb};
		foreach (ops[i]) begin
			randomIType(ops[i], w);
			presentAndCheck(w, 1'b1);
			// Read-merge-write for partial stores
			if (ops[i] inside {ctrlPkg::opSb, ctrlPkg::opSh})
				compareValue("memRe and memWe",
					32'(idExCtrl.memCtrl.memRe & idExCtrl.memCtrl.memWe), 32'd1);
		end
	endtask

	task automatic branchAndJumpOps();
		ctrlPkg::opcodeE    ops[$];
		ctrlPkg::instrWordT w;
		ops = '{ctrlPkg::opBeq, ctrlPkg::opBne, ctrlPkg::opBgtz, ctrlPkg::opBlez,
			ctrlPkg::opJ, ctrlPkg::opJal};
		foreach (ops[i]) begin
			randomIType(ops[i], w);
			presentAndCheck(w, 1'b1);
		end
		for (int k = 0; k < 2; k++) begin
			randomIType(ctrlPkg::opRegimm, w);
			w.iType.rt = 5'(k);
			presentAndCheck(w, 1'b1);
		end
		randomRType(ctrlPkg::fnJr, w);
		presentAndCheck(w, 1'b1);
		randomRType(ctrlPkg::fnJalr, w);
		presentAndCheck(w, 1'b1);
	endtask

	task automatic stallThenFlush();
		ctrlPkg::instrWordT w;
		ctrlPkg::idExCtrlT  held;
		randomIType(ctrlPkg::opLw, w);
		presentAndCheck(w, 1'b1);
		held  = idExCtrl;
		stall = 1'b1;
		randomRType(ctrlPkg::fnSub, w);
		instr = w;
		for (int i = 0; i < 3; i++) begin
			nextCycle();
			compareValue("idExCtrl under stall", 32'(idExCtrl), 32'(held));
			compareValue("exValid under stall", 32'(exValid), 32'd1);
		end
		// Flush wins over stall
		flush = 1'b1;
		nextCycle();
		compareValue("idExCtrl after flush", 32'(idExCtrl), 32'd0);
		compareValue("exValid after flush", 32'(exValid), 32'd0);
		flush = 1'b0;
		stall = 1'b0;
		presentAndCheck(w, 1'b1);
	endtask

	task automatic unknownAndInvalid();
		ctrlPkg::instrWordT words[$];
		ctrlPkg::instrWordT w;
		logic [31:0]        bits;
		takeBits(26, bits);
		words.push_back({6'd50, bits[25:0]});
		words.push_back({6'd16, bits[25:0]});
		words.push_back({6'd0, bits[25:6], 6'd1});
		words.push_back({6'd1, bits[25:21], 5'd5, bits[15:0]});
		foreach (words[i]) begin
			presentAndCheck(words[i], 1'b1);
			compareValue("branchCtrl.npcSel", 32'(branchCtrl.npcSel), 32'd0);
			compareValue("hazard.tuseRs", 32'(hazard.tuseRs), 32'd3);
			compareValue("hazard.tuseRt", 32'(hazard.tuseRt), 32'd3);
		end
		randomIType(ctrlPkg::opLw, w);
		presentAndCheck(w, 1'b0);
	endtask

	initial begin
		clk        = 1'b0;
		rstN       = 1'b0;
		instrValid = 1'b0;
		stall      = 1'b0;
		flush      = 1'b0;
		instr      = '0;
		lfsrState  = 16'd22;
		repeat (3) @(posedge clk);
		#1;
		rstN = 1'b1;
		afterResetIdle();
		aluAndHiLoOps();
		loadStoreOps();
		branchAndJumpOps();
		stallThenFlush();
		unknownAndInvalid();
		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

/* mipsControl.f */
common/ctrlPkg.sv
decode/branchDecode.sv
decode/aluDecode.sv
decode/memDecode.sv
decode/hazardTiming.sv
verilog/idExRegister.sv
verilog/mipsControl.sv
verif/mipsControlTb.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = mipsControlTb
FILELIST = mipsControl.f
BUILDDIR = obj_dir
LOG      = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILDDIR)

run: build
	./$(BUILDDIR)/V$(TOP) | tee $(LOG)
	grep -q "TEST RESULT: PASS" $(LOG)

lint:
	$(TOOL) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILDDIR) $(LOG)
